// ==== common/simd_pkg.sv ====
// Shared definitions for the SIMD execution unit
// Vector geometry, element width, source and opcode enums,
// handshake state and the latency class rule
`default_nettype none

package simd_pkg;

    localparam int VLEN   = 128;        // Vector register width
    localparam int ELEN   = 64;         // Lane and scalar word width
    localparam int LANES  = VLEN / ELEN;
    localparam int MASK_W = VLEN / 8;   // One mask bit per byte

    typedef logic [VLEN-1:0]   vec_t;
    typedef logic [ELEN-1:0]   elem_t;
    typedef logic [MASK_W-1:0] mask_t;
    typedef logic [4:0]        imm_t;
    typedef logic [1:0]        lat_t;   // Extra cycles beyond the base one

    typedef enum logic [1:0] {
        SEW_8,
        SEW_16,
        SEW_32,
        SEW_64
    } sew_t;

    typedef enum logic [1:0] {
        SRC_VV,     // vs1 as operand a
        SRC_VX,     // Replicated scalar
        SRC_VI      // Replicated sign-extended immediate
    } src_t;

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_MUL,
        OP_SEQ,
        OP_REDSUM,
        OP_MV_X_S,
        OP_EXT,
        OP_CNT
    } simd_op_t;

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DONE
    } hs_state_t;

    // Multiply needs pipeline stages, reduction one extra cycle
    function automatic lat_t lat_of(simd_op_t op, sew_t sew);
        if (op == OP_MUL) begin
            return (sew == SEW_64) ? 2'd2 : 2'd1;
        end
        if (op == OP_REDSUM) begin
            return 2'd1;
        end
        return 2'd0;
    endfunction

endpackage

`default_nettype wire

// ==== simd/simd_lane.sv ====
// One 64-bit SIMD lane
// Element-wise add, sub, logic and set-if-equal,
// plus a pipelined low-half multiplier
`timescale 1ns/1ps
`default_nettype none

module simd_lane import simd_pkg::*; (
    input  logic     clk_i,
    input  logic     rstn_i,
    input  simd_op_t op_i,
    input  sew_t     sew_i,
    input  elem_t    a_i,
    input  elem_t    b_i,
    output elem_t    res_o
);

    elem_t       seq_res;
    elem_t       mul_n;         // Narrow products, computed in one stage
    elem_t       mul_n_q;
    elem_t       p_ll_q;        // Low x low partial product
    logic [31:0] p_x_q;         // Sum of the cross products, low halves
    elem_t       mul64_q;

    // Byte-chained adder, the carry restarts at each element boundary
    function automatic elem_t add_sub(elem_t a, elem_t b, sew_t sew, logic sub);
        elem_t      bb;
        elem_t      r;
        logic       carry;
        logic [8:0] s;
        int         ebytes;
        ebytes = 1 << sew;
        bb     = sub ? ~b : b;
        carry  = sub;
        r      = '0;
        for (int k = 0; k < 8; k++) begin
            if ((k % ebytes) == 0) carry = sub;
            s = {1'b0, a[8*k +: 8]} + {1'b0, bb[8*k +: 8]} + {8'b0, carry};
            r[8*k +: 8] = s[7:0];
            carry = s[8];
        end
        return r;
    endfunction

    always_comb begin
        seq_res = '0;
        mul_n   = '0;
        case (sew_i)
            SEW_8: begin
                for (int i = 0; i < 8; i++) begin
                    seq_res[8*i] = (a_i[8*i +: 8] == b_i[8*i +: 8]);
                    mul_n[8*i +: 8] = a_i[8*i +: 8] * b_i[8*i +: 8];
                end
            end
            SEW_16: begin
                for (int i = 0; i < 4; i++) begin
                    seq_res[16*i] = (a_i[16*i +: 16] == b_i[16*i +: 16]);
                    mul_n[16*i +: 16] = a_i[16*i +: 16] * b_i[16*i +: 16];
                end
            end
            SEW_32: begin
                for (int i = 0; i < 2; i++) begin
                    seq_res[32*i] = (a_i[32*i +: 32] == b_i[32*i +: 32]);
                    mul_n[32*i +: 32] = a_i[32*i +: 32] * b_i[32*i +: 32];
                end
            end
            default: seq_res[0] = (a_i == b_i);     // 64-bit product uses two stages
        endcase
    end

    // Stage 1 partial products, stage 2 final 64-bit sum
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            mul_n_q <= '0;
            p_ll_q  <= '0;
            p_x_q   <= '0;
            mul64_q <= '0;
        end else begin
            mul_n_q <= mul_n;
            p_ll_q  <= a_i[31:0] * b_i[31:0];
            p_x_q   <= a_i[31:0] * b_i[63:32] + a_i[63:32] * b_i[31:0];
            mul64_q <= p_ll_q + {p_x_q, 32'b0};
        end
    end

    always_comb begin
        case (op_i)
            OP_ADD:         res_o = add_sub(a_i, b_i, sew_i, 1'b0);
            OP_SUB:         res_o = add_sub(a_i, b_i, sew_i, 1'b1);
            OP_AND:         res_o = a_i & b_i;
            OP_OR:          res_o = a_i | b_i;
            OP_XOR:         res_o = a_i ^ b_i;
            OP_MUL:         res_o = (sew_i == SEW_64) ? mul64_q : mul_n_q;
            OP_SEQ, OP_CNT: res_o = seq_res;        // Count needs the equal flags
            default:        res_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== simd/simd_decode.sv ====
// Request capture for the SIMD unit
// Start detection, operand replication and latency class
`timescale 1ns/1ps
`default_nettype none

module simd_decode import simd_pkg::*; (
    input  logic     clk_i,
    input  logic     rstn_i,
    input  logic     req_i,
    input  logic     idle_i,
    input  simd_op_t op_i,
    input  sew_t     sew_i,
    input  src_t     src_i,
    input  vec_t     vs1_i,
    input  vec_t     vs2_i,
    input  vec_t     old_vd_i,
    input  elem_t    rs1_i,
    input  imm_t     imm_i,
    input  mask_t    vm_i,
    output logic     start_o,
    output simd_op_t op_q_o,
    output sew_t     sew_q_o,
    output lat_t     lat_o,
    output vec_t     a_q_o,
    output vec_t     b_q_o,
    output elem_t    rs1_q_o,
    output vec_t     vs1_q_o,
    output vec_t     vs2_q_o,
    output vec_t     old_vd_q_o,
    output mask_t    vm_q_o
);

    elem_t scalar;
    vec_t  scalar_rep;
    vec_t  a_sel;

    assign start_o = req_i & idle_i;
    assign lat_o   = lat_of(op_i, sew_i);   // Loaded by execute on start

    // Immediate is sign-extended before replication
    assign scalar = (src_i == SRC_VI) ? {{(ELEN-5){imm_i[4]}}, imm_i} : rs1_i;

    always_comb begin
        case (sew_i)
            SEW_8:   scalar_rep = {16{scalar[7:0]}};
            SEW_16:  scalar_rep = {8{scalar[15:0]}};
            SEW_32:  scalar_rep = {4{scalar[31:0]}};
            default: scalar_rep = {2{scalar}};
        endcase
    end

    assign a_sel = (src_i == SRC_VV) ? vs1_i : scalar_rep;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            op_q_o  <= OP_ADD;
            sew_q_o <= SEW_8;
        end else if (start_o) begin
            op_q_o  <= op_i;
            sew_q_o <= sew_i;
        end
    end

    // Operand payload
    always_ff @(posedge clk_i) begin
        if (start_o) begin
            a_q_o      <= a_sel;
            b_q_o      <= vs2_i;
            rs1_q_o    <= rs1_i;
            vs1_q_o    <= vs1_i;
            vs2_q_o    <= vs2_i;
            old_vd_q_o <= old_vd_i;
            vm_q_o     <= vm_i;
        end
    end

endmodule

`default_nettype wire

// ==== simd/simd_execute.sv ====
// Execute stage of the SIMD unit
// Two lanes, the four-phase handshake FSM and the latency counter
`timescale 1ns/1ps
`default_nettype none

module simd_execute import simd_pkg::*; (
    input  logic     clk_i,
    input  logic     rstn_i,
    input  logic     req_i,
    input  logic     start_i,
    input  simd_op_t op_i,
    input  sew_t     sew_i,
    input  lat_t     lat_i,
    input  vec_t     a_i,
    input  vec_t     b_i,
    output logic     idle_o,
    output logic     done_o,
    output logic     ack_o,
    output vec_t     lane_vd_o
);

    hs_state_t state_q;
    lat_t      cnt_q;           // Remaining extra cycles

    genvar g;
    generate
        for (g = 0; g < LANES; g++) begin : gen_lane
            simd_lane i_lane (
                .clk_i  (clk_i),
                .rstn_i (rstn_i),
                .op_i   (op_i),
                .sew_i  (sew_i),
                .a_i    (a_i[ELEN*g +: ELEN]),
                .b_i    (b_i[ELEN*g +: ELEN]),
                .res_o  (lane_vd_o[ELEN*g +: ELEN])
            );
        end
    endgenerate

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q <= BUSY;
                        cnt_q   <= lat_i;
                    end
                end
                BUSY: begin
                    if (cnt_q == 2'd0) begin
                        state_q <= DONE;
                    end else begin
                        cnt_q <= cnt_q - 2'd1;
                    end
                end
                DONE: begin
                    // Hold the result until the requester lets go
                    if (!req_i) state_q <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Result stage samples lane data on this pulse
    assign done_o = (state_q == BUSY) && (cnt_q == 2'd0);
    assign ack_o  = (state_q == DONE);
    assign idle_o = (state_q == IDLE);

endmodule

`default_nettype wire

// ==== simd/simd_result.sv ====
// Result stage of the SIMD unit
// Sum reduction, scalar moves, extract, equal count,
// mask merge and the output holding registers
`timescale 1ns/1ps
`default_nettype none

module simd_result import simd_pkg::*; (
    input  logic     clk_i,
    input  logic     rstn_i,
    input  logic     done_i,
    input  simd_op_t op_i,
    input  sew_t     sew_i,
    input  vec_t     lane_vd_i,
    input  vec_t     vs1_i,
    input  vec_t     vs2_i,
    input  vec_t     old_vd_i,
    input  elem_t    rs1_i,
    input  mask_t    vm_i,
    input  logic     ack_i,
    output vec_t     vd_o,
    output elem_t    rd_o,
    output logic     vd_we_o,
    output logic     rd_we_o
);

    logic [7:0]  sum8;
    logic [15:0] sum16;
    logic [31:0] sum32;
    elem_t       sum64;
    vec_t        red_vd;
    vec_t        merged_vd;
    logic [3:0]  align;         // Clears byte index bits below element start
    logic [15:0] eq_flags;
    logic        run;
    elem_t       rd_next;
    logic        is_elem;
    logic        is_scalar;
    logic        vd_we_q;
    logic        rd_we_q;

    assign is_elem   = op_i inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_MUL, OP_SEQ};
    assign is_scalar = op_i inside {OP_MV_X_S, OP_EXT, OP_CNT};

    // Reduction seeded with element 0 of vs1
    always_comb begin
        sum8  = vs1_i[7:0];
        sum16 = vs1_i[15:0];
        sum32 = vs1_i[31:0];
        sum64 = vs1_i[63:0];
        for (int i = 0; i < 16; i++) sum8 = sum8 + vs2_i[8*i +: 8];
        for (int i = 0; i < 8; i++) sum16 = sum16 + vs2_i[16*i +: 16];
        for (int i = 0; i < 4; i++) sum32 = sum32 + vs2_i[32*i +: 32];
        for (int i = 0; i < 2; i++) sum64 = sum64 + vs2_i[64*i +: 64];
        red_vd = old_vd_i;
        case (sew_i)
            SEW_8:   red_vd[7:0]  = sum8;
            SEW_16:  red_vd[15:0] = sum16;
            SEW_32:  red_vd[31:0] = sum32;
            default: red_vd[63:0] = sum64;
        endcase
    end

    // Each byte follows the mask bit of its element's lowest byte
    always_comb begin
        case (sew_i)
            SEW_8:   align = 4'hf;
            SEW_16:  align = 4'he;
            SEW_32:  align = 4'hc;
            default: align = 4'h8;
        endcase
        for (int b = 0; b < MASK_W; b++) begin
            merged_vd[8*b +: 8] = vm_i[4'(b) & align] ? lane_vd_i[8*b +: 8]
                                                      : old_vd_i[8*b +: 8];
        end
    end

    // Zero-extended scalar results
    always_comb begin
        eq_flags = '0;
        rd_next  = '0;
        run      = 1'b1;
        case (sew_i)
            SEW_8:   for (int i = 0; i < 16; i++) eq_flags[i] = lane_vd_i[8*i];
            SEW_16:  for (int i = 0; i < 8; i++) eq_flags[i] = lane_vd_i[16*i];
            SEW_32:  for (int i = 0; i < 4; i++) eq_flags[i] = lane_vd_i[32*i];
            default: for (int i = 0; i < 2; i++) eq_flags[i] = lane_vd_i[64*i];
        endcase
        case (op_i)
            OP_MV_X_S: begin
                case (sew_i)
                    SEW_8:   rd_next = {56'b0, vs2_i[7:0]};
                    SEW_16:  rd_next = {48'b0, vs2_i[15:0]};
                    SEW_32:  rd_next = {32'b0, vs2_i[31:0]};
                    default: rd_next = vs2_i[63:0];
                endcase
            end
            OP_EXT: begin
                case (sew_i)        // Out of range index gives zero
                    SEW_8:   if (rs1_i < 16) rd_next = {56'b0, vs2_i[8*rs1_i[3:0] +: 8]};
                    SEW_16:  if (rs1_i < 8) rd_next = {48'b0, vs2_i[16*rs1_i[2:0] +: 16]};
                    SEW_32:  if (rs1_i < 4) rd_next = {32'b0, vs2_i[32*rs1_i[1:0] +: 32]};
                    default: if (rs1_i < 2) rd_next = vs2_i[64*rs1_i[0] +: 64];
                endcase
            end
            OP_CNT: begin
                for (int i = 0; i < 16; i++) begin
                    run = run & eq_flags[i];
                    if (run) rd_next = elem_t'(i + 1);
                end
            end
            default: rd_next = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            vd_o    <= '0;
            rd_o    <= '0;
            vd_we_q <= 1'b0;
            rd_we_q <= 1'b0;
        end else if (done_i) begin
            vd_o    <= (op_i == OP_REDSUM) ? red_vd : merged_vd;
            rd_o    <= rd_next;
            vd_we_q <= is_elem | (op_i == OP_REDSUM);
            rd_we_q <= is_scalar;
        end
    end

    assign vd_we_o = vd_we_q & ack_i;   // Only valid with the handshake
    assign rd_we_o = rd_we_q & ack_i;

endmodule

`default_nettype wire

// ==== simd/simd_unit.sv ====
// Top level of the SIMD execution unit
// Decode, execute and result stages behind a req/ack handshake
`timescale 1ns/1ps
`default_nettype none

module simd_unit import simd_pkg::*; (
    input  logic     clk_i,
    input  logic     rstn_i,
    input  logic     req_i,
    input  simd_op_t op_i,
    input  sew_t     sew_i,
    input  src_t     src_i,
    input  vec_t     vs1_i,
    input  vec_t     vs2_i,
    input  elem_t    rs1_i,
    input  imm_t     imm_i,
    input  vec_t     old_vd_i,
    input  mask_t    vm_i,
    output logic     ack_o,
    output vec_t     vd_o,
    output elem_t    rd_o,
    output logic     vd_we_o,
    output logic     rd_we_o
);

    logic     start;
    logic     idle;
    logic     done;
    simd_op_t op_q;
    sew_t     sew_q;
    lat_t     lat;
    vec_t     a_q;
    vec_t     b_q;
    elem_t    rs1_q;
    vec_t     vs1_q;
    vec_t     vs2_q;
    vec_t     old_vd_q;
    mask_t    vm_q;
    vec_t     lane_vd;

    simd_decode i_decode (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .req_i      (req_i),
        .idle_i     (idle),
        .op_i       (op_i),
        .sew_i      (sew_i),
        .src_i      (src_i),
        .vs1_i      (vs1_i),
        .vs2_i      (vs2_i),
        .old_vd_i   (old_vd_i),
        .rs1_i      (rs1_i),
        .imm_i      (imm_i),
        .vm_i       (vm_i),
        .start_o    (start),
        .op_q_o     (op_q),
        .sew_q_o    (sew_q),
        .lat_o      (lat),
        .a_q_o      (a_q),
        .b_q_o      (b_q),
        .rs1_q_o    (rs1_q),
        .vs1_q_o    (vs1_q),
        .vs2_q_o    (vs2_q),
        .old_vd_q_o (old_vd_q),
        .vm_q_o     (vm_q)
    );

    simd_execute i_execute (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .req_i     (req_i),
        .start_i   (start),
        .op_i      (op_q),
        .sew_i     (sew_q),
        .lat_i     (lat),
        .a_i       (a_q),
        .b_i       (b_q),
        .idle_o    (idle),
        .done_o    (done),
        .ack_o     (ack_o),
        .lane_vd_o (lane_vd)
    );

    simd_result i_result (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .done_i    (done),
        .op_i      (op_q),
        .sew_i     (sew_q),
        .lane_vd_i (lane_vd),
        .vs1_i     (vs1_q),
        .vs2_i     (vs2_q),
        .old_vd_i  (old_vd_q),
        .rs1_i     (rs1_q),
        .vm_i      (vm_q),
        .ack_i     (ack_o),
        .vd_o      (vd_o),
        .rd_o      (rd_o),
        .vd_we_o   (vd_we_o),
        .rd_we_o   (rd_we_o)
    );

endmodule

`default_nettype wire

// ==== verif/simd_assertions.sv ====
// Concurrent handshake and reset checks for the execute stage
// Bound into every simd_execute instance
`timescale 1ns/1ps
`default_nettype none

module simd_assertions import simd_pkg::*; (
    input logic      clk_i,
    input logic      rstn_i,
    input logic      req_i,
    input logic      ack_i,
    input hs_state_t state_i
);

    // Ack only answers a request that was already up
    ack_needs_req: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $rose(ack_i) |-> $past(req_i))
        else $error("ack rose without a pending request");

    ack_holds: assert property (@(posedge clk_i) disable iff (!rstn_i)
        ack_i && req_i |=> ack_i)
        else $error("ack dropped while req was still high");

    reset_idle: assert property (@(posedge clk_i)
        !rstn_i |-> state_i == IDLE)
        else $error("handshake FSM not idle during reset");

endmodule

bind simd_execute simd_assertions i_assertions (
    .clk_i   (clk_i),
    .rstn_i  (rstn_i),
    .req_i   (req_i),
    .ack_i   (ack_o),
    .state_i (state_q)
);

`default_nettype wire

// ==== verif/simd_ref_model.svh ====
// Reference model for the SIMD unit testbench
// Element access, operand replication, element operations, mask merge,
// sum reduction, scalar extraction, leading-equal count and latency rule
`ifndef SIMD_REF_MODEL_SVH
`define SIMD_REF_MODEL_SVH

function automatic elem_t width_mask(int w);
    return ~(64'hffff_ffff_ffff_ffff << w);   // Shift by 64 leaves all ones
endfunction

function automatic elem_t get_elem(vec_t v, sew_t sew, int i);
    int w;
    w = 8 << sew;
    return elem_t'(v >> (i * w)) & width_mask(w);
endfunction

function automatic vec_t put_elem(vec_t v, sew_t sew, int i, elem_t x);
    int   w;
    vec_t m;
    w = 8 << sew;
    m = vec_t'(width_mask(w)) << (i * w);
    return (v & ~m) | ((vec_t'(x) << (i * w)) & m);
endfunction

// Operand a as the lanes see it
function automatic vec_t replicate_operand(src_t src, sew_t sew, vec_t vs1, elem_t rs1,
                                           imm_t imm);
    elem_t x;
    vec_t  r;
    if (src == SRC_VV) begin
        return vs1;
    end
    x = (src == SRC_VI) ? {{59{imm[4]}}, imm} : rs1;
    r = '0;
    for (int i = 0; i < VLEN / (8 << sew); i++) begin
        r = put_elem(r, sew, i, x);
    end
    return r;
endfunction

function automatic vec_t element_result(simd_op_t op, sew_t sew, vec_t a, vec_t b);
    vec_t  r;
    elem_t x;
    elem_t y;
    elem_t z;
    r = '0;
    for (int i = 0; i < VLEN / (8 << sew); i++) begin
        x = get_elem(a, sew, i);
        y = get_elem(b, sew, i);
        case (op)
            OP_ADD:  z = x + y;
            OP_SUB:  z = x - y;
            OP_AND:  z = x & y;
            OP_OR:   z = x | y;
            OP_XOR:  z = x ^ y;
            OP_MUL:  z = x * y;             // Truncated to the element by put_elem
            OP_SEQ:  z = elem_t'(x == y);
            default: z = '0;
        endcase
        r = put_elem(r, sew, i, z);
    end
    return r;
endfunction

// An element is written when the mask bit of its lowest byte is set
function automatic vec_t merge_masked(sew_t sew, vec_t res, vec_t old, mask_t vm);
    vec_t r;
    r = old;
    for (int i = 0; i < VLEN / (8 << sew); i++) begin
        if (vm[i * (1 << sew)]) begin
            r = put_elem(r, sew, i, get_elem(res, sew, i));
        end
    end
    return r;
endfunction

function automatic vec_t reduce_sum(sew_t sew, vec_t vs1, vec_t vs2, vec_t old);
    elem_t s;
    s = get_elem(vs1, sew, 0);
    for (int i = 0; i < VLEN / (8 << sew); i++) begin
        s = s + get_elem(vs2, sew, i);
    end
    return put_elem(old, sew, 0, s);
endfunction

function automatic elem_t extract_element(sew_t sew, vec_t v, elem_t idx);
    if (idx >= elem_t'(VLEN / (8 << sew))) begin
        return '0;
    end
    return get_elem(v, sew, int'(idx));
endfunction

function automatic elem_t count_leading_equal(sew_t sew, vec_t a, vec_t b);
    int c;
    c = 0;
    while (c < VLEN / (8 << sew) && get_elem(a, sew, c) == get_elem(b, sew, c)) begin
        c++;
    end
    return elem_t'(c);
endfunction

// Extra cycles between accept and result
function automatic int expect_latency(simd_op_t op, sew_t sew);
    if (op == OP_MUL && sew == SEW_64) begin
        return 2;
    end
    if (op == OP_MUL || op == OP_REDSUM) begin
        return 1;
    end
    return 0;
endfunction

`endif

// ==== verif/simd_tb.sv ====
// Testbench for the SIMD execution unit
// Clock and reset, LFSR stimulus, four-phase handshake driver,
// result checks against the reference model and the final report
`timescale 1ns/1ps
`default_nettype none

module simd_tb import simd_pkg::*; ();

    localparam int TIMEOUT = 20;    // Edges allowed for any single wait

    logic     clk;
    logic     rstn;
    logic     req;
    simd_op_t op;
    sew_t     sew;
    src_t     src;
    vec_t     vs1;
    vec_t     vs2;
    elem_t    rs1;
    imm_t     imm;
    vec_t     old_vd;
    mask_t    vm;
    logic     ack;
    vec_t     vd;
    elem_t    rd;
    logic     vd_we;
    logic     rd_we;

    logic [31:0] lfsr;
    logic        timed_out;
    vec_t        got_vd;            // Outputs seen at the first ack sample
    elem_t       got_rd;
    logic        got_vd_we;
    logic        got_rd_we;
    int          test_checks;
    int          test_errors;
    int          total_checks;
    int          total_errors;
    int          tests_run;
    int          tests_failed;

    `include "simd_ref_model.svh"

    simd_unit i_dut (
        .clk_i    (clk),
        .rstn_i   (rstn),
        .req_i    (req),
        .op_i     (op),
        .sew_i    (sew),
        .src_i    (src),
        .vs1_i    (vs1),
        .vs2_i    (vs2),
        .rs1_i    (rs1),
        .imm_i    (imm),
        .old_vd_i (old_vd),
        .vm_i     (vm),
        .ack_o    (ack),
        .vd_o     (vd),
        .rd_o     (rd),
        .vd_we_o  (vd_we),
        .rd_we_o  (rd_we)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Galois LFSR, one step for each bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r    = {r[62:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic vec_t rand_vec();
        return {rand_bits(64), rand_bits(64)};
    endfunction

    task automatic random_operands();
        src    = src_t'(2'(rand_bits(2) % 3));
        vs1    = rand_vec();
        vs2    = rand_vec();
        old_vd = rand_vec();
        rs1    = rand_bits(64);
        imm    = imm_t'(rand_bits(5));
        vm     = mask_t'(rand_bits(16));
    endtask

    task automatic check_value(input string name, input vec_t exp, input vec_t act);
        test_checks++;
        assert (act === exp) else begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic end_test(input string name);
        $display("Test %s: %0d checks, %0d errors", name, test_checks, test_errors);
        tests_run++;
        if (test_errors != 0 || timed_out) begin
            tests_failed++;
        end
        total_checks += test_checks;
        total_errors += test_errors;
        test_checks  = 0;
        test_errors  = 0;
    endtask

    // One request with extra cycles of req after ack, starting on a falling edge
    task automatic run_op(input string name, input int hold, output int lat_edges,
                          output int fall_edges);
        int n;
        lat_edges  = 0;
        fall_edges = 0;
        req = 1'b1;
        n   = 0;
        while (!ack && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!ack) begin
            $display("Error: %s got no ack within %0d cycles of the request", name, TIMEOUT);
            timed_out = 1'b1;
            req = 1'b0;
            return;
        end
        lat_edges = n - 1;          // First rising edge accepts the request
        got_vd    = vd;
        got_rd    = rd;
        got_vd_we = vd_we;
        got_rd_we = rd_we;
        for (int k = 0; k < hold; k++) begin
            @(negedge clk);
            check_value({name, " held vd"}, got_vd, vd);
            check_value({name, " held rd"}, 128'(got_rd), 128'(rd));
            check_value({name, " held ack and enables"},
                        128'({1'b1, got_vd_we, got_rd_we}), 128'({ack, vd_we, rd_we}));
        end
        req = 1'b0;
        n   = 0;
        while (ack && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (ack) begin
            $display("Error: %s, ack still high %0d cycles after req dropped", name, TIMEOUT);
            timed_out = 1'b1;
            return;
        end
        fall_edges = n;
    endtask

    task automatic reset_outputs();
        check_value("reset ack and enables", '0, 128'({ack, vd_we, rd_we}));
        check_value("reset vd", '0, vd);
        check_value("reset rd", '0, 128'(rd));
    endtask

    task automatic element_ops();
        vec_t a;
        vec_t exp_vd;
        int   lat_edges;
        int   fall_edges;
        for (int t = 0; t < 200 && !timed_out; t++) begin
            random_operands();
            op     = simd_op_t'(4'(rand_bits(3) % 7));   // ADD up to SEQ
            sew    = sew_t'(2'(rand_bits(2)));
            a      = replicate_operand(src, sew, vs1, rs1, imm);
            exp_vd = merge_masked(sew, element_result(op, sew, a, vs2), old_vd, vm);
            run_op("element_ops", 0, lat_edges, fall_edges);
            if (!timed_out) begin
                check_value("element_ops vd", exp_vd, got_vd);
                check_value("element_ops enables", 128'(2'b10),
                            128'({got_vd_we, got_rd_we}));
            end
        end
    endtask

    task automatic latency_rule();
        vec_t a;
        vec_t exp_vd;
        int   lat_edges;
        int   fall_edges;
        for (int t = 0; t < 9 && !timed_out; t++) begin
            random_operands();
            if (t < 3) begin
                op  = OP_ADD;
                sew = sew_t'(2'(rand_bits(2)));
            end else begin
                op  = OP_MUL;
                sew = (t < 6) ? SEW_32 : SEW_64;
            end
            a      = replicate_operand(src, sew, vs1, rs1, imm);
            exp_vd = merge_masked(sew, element_result(op, sew, a, vs2), old_vd, vm);
            run_op("latency", 0, lat_edges, fall_edges);
            if (!timed_out) begin
                check_value("latency edges", 128'(1 + expect_latency(op, sew)),
                            128'(lat_edges));
                check_value("latency vd", exp_vd, got_vd);
            end
        end
    endtask

    task automatic reduction_sum();
        vec_t exp_vd;
        int   lat_edges;
        int   fall_edges;
        for (int t = 0; t < 16 && !timed_out; t++) begin
            random_operands();
            op     = OP_REDSUM;
            sew    = sew_t'(2'(t % 4));
            exp_vd = reduce_sum(sew, vs1, vs2, old_vd);
            run_op("redsum", 0, lat_edges, fall_edges);
            if (!timed_out) begin
                check_value("redsum vd", exp_vd, got_vd);
                check_value("redsum enables", 128'(2'b10), 128'({got_vd_we, got_rd_we}));
            end
        end
    endtask

    task automatic scalar_moves();
        elem_t exp_rd;
        int    lat_edges;
        int    fall_edges;
        for (int t = 0; t < 24 && !timed_out; t++) begin
            random_operands();
            sew = sew_t'(2'(t % 4));
            if (t < 4) begin
                op     = OP_MV_X_S;
                exp_rd = extract_element(sew, vs2, '0);
            end else begin
                op = OP_EXT;
                if (t < 20) begin
                    rs1 = rand_bits(5);     // Index both in and past the range
                end
                exp_rd = extract_element(sew, vs2, rs1);
            end
            run_op("scalar_moves", 0, lat_edges, fall_edges);
            if (!timed_out) begin
                check_value("scalar_moves rd", 128'(exp_rd), 128'(got_rd));
                check_value("scalar_moves enables", 128'(2'b01),
                            128'({got_vd_we, got_rd_we}));
            end
        end
    endtask

    task automatic equal_count();
        elem_t exp_rd;
        int    n;
        int    k;
        int    lat_edges;
        int    fall_edges;
        for (int t = 0; t < 16 && !timed_out; t++) begin
            random_operands();
            op  = OP_CNT;
            src = SRC_VV;
            sew = sew_t'(2'(t % 4));
            n   = VLEN / (8 << sew);
            k   = int'(rand_bits(5) % 64'(n + 1));
            for (int i = 0; i < k; i++) begin
                vs2 = put_elem(vs2, sew, i, get_elem(vs1, sew, i));
            end
            if (k < n) begin
                vs2 = put_elem(vs2, sew, k, get_elem(vs1, sew, k) ^ elem_t'(1));
            end
            exp_rd = count_leading_equal(sew, vs1, vs2);
            run_op("equal_count", 0, lat_edges, fall_edges);
            if (!timed_out) begin
                check_value("equal_count rd", 128'(exp_rd), 128'(got_rd));
                check_value("equal_count enables", 128'(2'b01),
                            128'({got_vd_we, got_rd_we}));
            end
        end
    endtask

    task automatic back_pressure();
        vec_t a;
        vec_t exp_vd;
        int   hold;
        int   lat_edges;
        int   fall_edges;
        for (int t = 0; t < 8 && !timed_out; t++) begin
            random_operands();
            op     = simd_op_t'(4'(rand_bits(3) % 7));
            sew    = sew_t'(2'(rand_bits(2)));
            hold   = 1 + int'(rand_bits(3));
            a      = replicate_operand(src, sew, vs1, rs1, imm);
            exp_vd = merge_masked(sew, element_result(op, sew, a, vs2), old_vd, vm);
            run_op("back_pressure", hold, lat_edges, fall_edges);
            if (!timed_out) begin
                check_value("back_pressure vd", exp_vd, got_vd);
                check_value("back_pressure ack fall edges", 128'(1), 128'(fall_edges));
            end
        end
    endtask

    initial begin
        lfsr         = 32'hf46c571b;
        timed_out    = 1'b0;
        test_checks  = 0;
        test_errors  = 0;
        total_checks = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        rstn   = 1'b0;
        req    = 1'b0;
        op     = OP_ADD;
        sew    = SEW_8;
        src    = SRC_VV;
        vs1    = '0;
        vs2    = '0;
        rs1    = '0;
        imm    = '0;
        old_vd = '0;
        vm     = '0;
        repeat (4) @(negedge clk);
        rstn = 1'b1;

        reset_outputs();
        end_test("reset_outputs");
        element_ops();
        end_test("element_ops");
        latency_rule();
        end_test("latency");
        reduction_sum();
        end_test("redsum");
        scalar_moves();
        end_test("scalar_moves");
        equal_count();
        end_test("equal_count");
        back_pressure();
        end_test("back_pressure");

        $display("Tests: %0d run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, total_checks, total_errors);
        if (total_errors == 0 && !timed_out) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+verif
common/simd_pkg.sv
simd/simd_lane.sv
simd/simd_decode.sv
simd/simd_execute.sv
simd/simd_result.sv
simd/simd_unit.sv
verif/simd_assertions.sv
verif/simd_tb.sv

// ==== Makefile ====
# Verilator build and run of the SIMD unit testbench
SRCS := $(wildcard common/*.sv simd/*.sv verif/*.sv verif/*.svh)

.PHONY: all run clean

all: run

obj_dir/Vsimd_tb: $(SRCS) filelist.f
	verilator --binary --timing --assert -Wno-fatal --top-module simd_tb -f filelist.f

run: obj_dir/Vsimd_tb
	@out="$$(./obj_dir/Vsimd_tb)"; echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir
